/* tb.f */
hdl/lsuPkg.sv
hdl/storePath.sv
hdl/dtim.sv
hdl/loadPath.sv
hdl/lrscReservation.sv
hdl/lsu.sv
sim/lsu_props.sv
sim/lsuTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the load/store unit testbench with Verilator
# Exit status is nonzero unless the pass line shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module lsuTb -o lsuSim -f tb.f \
  && ./obj_dir/lsuSim | tee /dev/stderr | grep -F -- '*** PASSED ***' > /dev/null \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }

/* sim/lsuTb.sv */
`timescale 1ns/10ps

module lsuTb import lsuPkg::*; ();

  localparam int MAX_CYCLES = 4000;          // Watchdog limit
  localparam int MEM_BYTES  = 512;           // 64 words of 8 bytes

  logic    clk = 1'b0;
  logic    reset;
  logic    StallM;
  logic    FlushM;
  logic    StallW;
  logic    BigEndianM;
  memReq_t memReqE;
  word_t   WriteDataM;
  word_t   ReadDataW;
  logic    SquashSCW;
  logic    LoadMisalignedFaultM;
  logic    StoreAmoMisalignedFaultM;

  logic [7:0] refMem [MEM_BYTES];            // Byte image of the DTIM
  logic       resValid;                      // Expected reservation
  word_t      resAdr;                        // Reserved doubleword
  integer     seed = 15418;
  string      curTest;
  int         checks;
  int         errors;
  int         testErrors;                    // Error count when the test began
  int         testsRun;
  int         testsFailed;
  word_t      lastRead;                      // Sampled in W
  logic       lastSquash;
  logic       lastLdFault;                   // Sampled in M
  logic       lastStFault;

  lsu #(
    .DTIM_ADR_BITS       (6),
    .BIG_ENDIAN_SUPPORTED(1)
  ) dut_i (.*);

  always #2 clk = ~clk;                      // 4 ns period

  ////////////////////
  // Reference model
  ////////////////////

  function automatic int sizeBytes(memSize_e size);
    return 1 << size[1:0];
  endfunction

  // Access must sit on a multiple of its size
  function automatic logic misaligned(word_t adr, memSize_e size);
    return (adr[2:0] & 3'(sizeBytes(size) - 1)) != 3'd0;
  endfunction

  // Memory byte that holds byte k of the access
  function automatic logic [8:0] byteAdr(word_t adr, int k, logic big);
    logic [2:0] lane;
    lane = adr[2:0] + 3'(k);
    if (big) lane = 3'd7 - lane;             // Big-endian mirrors the lanes
    return {adr[8:3], lane};
  endfunction

  task automatic modelWrite(word_t adr, memSize_e size, word_t data, logic big);
    for (int k = 0; k < sizeBytes(size); k++) begin
      refMem[byteAdr(adr, k, big)] = data[8*k +: 8];
    end
  endtask

  function automatic word_t modelRead(word_t adr, memSize_e size, logic big);
    word_t raw;
    word_t ones;
    int    n;
    n    = sizeBytes(size);
    raw  = '0;
    ones = '1;
    for (int k = 0; k < n; k++) raw[8*k +: 8] = refMem[byteAdr(adr, k, big)];
    // Signed codes copy the top bit of the subword upward
    if (!size[2] && n < 8 && raw[8*n-1]) raw = raw | (ones << (8*n));
    return raw;
  endfunction

  ////////////////////
  // Checking
  ////////////////////

  task automatic checkValue(string what, word_t expected, word_t actual);
    checks++;
    assert (actual === expected)
    else begin
      $display("mismatch %s %s: expected %h, actual %h", curTest, what, expected, actual);
      errors++;
    end
  endtask

  task automatic startTest(string name);
    curTest    = name;
    testErrors = errors;
  endtask

  task automatic endTest();
    testsRun++;
    if (errors == testErrors) begin
      $display("test %s: ok", curTest);
    end else begin
      testsFailed++;
      $display("test %s: %0d errors", curTest, errors - testErrors);
    end
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  // Starts on a falling edge and ends two falling edges later with W sampled
  task automatic runAccess(memRw_t rw, memSize_e size, logic lrsc, word_t adr,
                           word_t data, logic big, logic flush);
    memReq_t req;
    req.rw      = rw;
    req.size    = size;
    req.lrsc    = lrsc;
    req.adr     = adr;
    memReqE     = req;                       // E stage
    WriteDataM  = data;
    BigEndianM  = big;
    FlushM      = flush;                     // Kills it on the way into M
    @(negedge clk);
    lastLdFault = LoadMisalignedFaultM;
    lastStFault = StoreAmoMisalignedFaultM;
    memReqE     = '0;                        // Idle slot after every access
    FlushM      = 1'b0;
    @(negedge clk);
    lastRead    = ReadDataW;
    lastSquash  = SquashSCW;
  endtask

  task automatic doStore(memSize_e size, word_t adr, word_t data, logic big, logic lrsc);
    logic fault;
    logic scFail;
    fault  = misaligned(adr, size);
    scFail = lrsc & (~resValid | (resAdr != (adr >> 3)));
    runAccess(RW_WRITE, size, lrsc, adr, data, big, 1'b0);
    checkValue("store fault", {63'b0, fault}, {63'b0, lastStFault});
    checkValue("squash", {63'b0, scFail}, {63'b0, lastSquash});
    if (lrsc) resValid = 1'b0;               // Every SC ends the reservation
    if (!fault && !scFail) modelWrite(adr, size, data, big);
  endtask

  task automatic doLoad(memSize_e size, word_t adr, logic big, logic lrsc);
    logic fault;
    fault = misaligned(adr, size);
    runAccess(RW_READ, size, lrsc, adr, '0, big, 1'b0);
    checkValue("load fault", {63'b0, fault}, {63'b0, lastLdFault});
    checkValue("squash", 64'd0, {63'b0, lastSquash});
    if (!fault) checkValue("load data", modelRead(adr, size, big), lastRead);
    if (lrsc) begin
      resValid = 1'b1;
      resAdr   = adr >> 3;
    end
  endtask

  initial begin
    memReq_t    req;
    word_t      adr;
    word_t      data;
    word_t      held;
    word_t      expected;
    memSize_e   sz;
    logic [2:0] off;
    logic [1:0] pick;
    int         waited;
    reset      = 1'b1;
    StallM     = 1'b0;
    FlushM     = 1'b0;
    StallW     = 1'b0;
    BigEndianM = 1'b0;
    memReqE    = '0;
    WriteDataM = '0;
    resValid   = 1'b0;
    resAdr     = '0;
    repeat (4) @(negedge clk);
    reset = 1'b0;

    // Fill every word so the model matches the whole DTIM
    startTest("dwordFill");
    for (int i = 0; i < 64; i++) begin
      doStore(SIZE_D, word_t'(i * 8), {$random(seed), $random(seed)}, 1'b0, 1'b0);
    end
    for (int i = 0; i < 64; i++) doLoad(SIZE_D, word_t'(i * 8), 1'b0, 1'b0);
    endTest();

    startTest("subwordRandom");
    for (int i = 0; i < 40; i++) begin
      pick = 2'($random(seed));
      if (pick == 2'd3) pick = 2'd2;         // Byte, half or word
      sz  = memSize_e'({1'b0, pick});
      off = 3'($random(seed)) & ~3'(sizeBytes(sz) - 1);
      adr = {55'b0, 6'($random(seed)), off};
      doStore(sz, adr, {$random(seed), $random(seed)}, 1'b0, 1'b0);
      for (int s = 0; s < 7; s++) begin
        sz = memSize_e'(3'(s));
        doLoad(sz, adr & ~word_t'(sizeBytes(sz) - 1), 1'b0, 1'b0);
      end
    end
    endTest();

    startTest("bigEndian");
    for (int i = 0; i < 12; i++) begin
      sz  = memSize_e'({1'b0, 2'($random(seed))});
      off = 3'($random(seed)) & ~3'(sizeBytes(sz) - 1);
      adr = {55'b0, 6'($random(seed)), off};
      doStore(sz, adr, {$random(seed), $random(seed)}, 1'b1, 1'b0);
      doLoad(sz, adr, 1'b1, 1'b0);
      doLoad(SIZE_D, {adr[63:3], 3'b000}, 1'b0, 1'b0);   // Memory order seen LE
    end
    data = {$random(seed), $random(seed)};
    doStore(SIZE_D, 64'h1f8, data, 1'b0, 1'b0);
    doLoad(SIZE_D, 64'h1f8, 1'b1, 1'b0);
    // Byte k of the result is byte 7-k of the stored word
    for (int k = 0; k < 8; k++) begin
      expected[8*k +: 8] = data[8*(7-k) +: 8];
    end
    checkValue("reversed word", expected, lastRead);
    endTest();

    startTest("misaligned");
    doStore(SIZE_H, 64'h0a1, {$random(seed), $random(seed)}, 1'b0, 1'b0);
    doStore(SIZE_W, 64'h0a2, {$random(seed), $random(seed)}, 1'b0, 1'b0);
    doStore(SIZE_D, 64'h0a4, {$random(seed), $random(seed)}, 1'b1, 1'b0);
    doLoad(SIZE_D, 64'h0a0, 1'b0, 1'b0);    // Word must be untouched
    doLoad(SIZE_H, 64'h0a3, 1'b0, 1'b0);
    doLoad(SIZE_WU, 64'h0a6, 1'b0, 1'b0);
    endTest();

    startTest("lrsc");
    doLoad(SIZE_D, 64'h080, 1'b0, 1'b1);    // LR
    doStore(SIZE_D, 64'h080, {$random(seed), $random(seed)}, 1'b0, 1'b1);
    doLoad(SIZE_D, 64'h080, 1'b0, 1'b0);
    doStore(SIZE_D, 64'h080, {$random(seed), $random(seed)}, 1'b0, 1'b1);  // Second SC
    doLoad(SIZE_D, 64'h080, 1'b0, 1'b1);
    doStore(SIZE_D, 64'h100, {$random(seed), $random(seed)}, 1'b0, 1'b1);  // Other dword
    doStore(SIZE_W, 64'h104, {$random(seed), $random(seed)}, 1'b0, 1'b1);  // No LR left
    doLoad(SIZE_D, 64'h100, 1'b0, 1'b0);
    doLoad(SIZE_D, 64'h080, 1'b0, 1'b0);
    endTest();

    startTest("flushStall");
    runAccess(RW_WRITE, SIZE_D, 1'b0, 64'h040, {$random(seed), $random(seed)}, 1'b0, 1'b1);
    doLoad(SIZE_D, 64'h040, 1'b0, 1'b0);    // Model never saw the flushed write
    doStore(SIZE_D, 64'h048, {$random(seed), $random(seed)}, 1'b0, 1'b0);
    expected = modelRead(64'h048, SIZE_D, 1'b0);
    req.rw   = RW_READ;
    req.size = SIZE_D;
    req.lrsc = 1'b0;
    req.adr  = 64'h048;
    memReqE  = req;
    @(negedge clk);
    held     = ReadDataW;                    // W value while the load sits in M
    memReqE  = '0;
    StallM   = 1'b1;                         // Load parked in M
    StallW   = 1'b1;
    for (int i = 0; i < 3; i++) begin
      @(negedge clk);
      checkValue("held data", held, ReadDataW);
    end
    StallM = 1'b0;
    StallW = 1'b0;
    waited = 0;
    while (ReadDataW === held && waited < 4) begin
      @(negedge clk);
      waited++;
    end
    if (ReadDataW === held) begin
      $display("%s: ReadDataW still held %0d cycles after the stall ended", curTest, waited);
      errors++;
    end
    checkValue("released data", expected, ReadDataW);
    endTest();

    errors += dut_i.lsuProps_i.failCount;   // Bound property failures
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             testsRun, testsFailed, checks, errors);
    if (errors == 0) $display("*** PASSED ***");
    else             $display("*** FAILED ***");
    $finish;
  end

  // Watchdog
  initial begin
    repeat (MAX_CYCLES) @(posedge clk);
    $display("Simulation timed out after %0d cycles", MAX_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

/* sim/lsu_props.sv */
`timescale 1ns/10ps

// Concurrent checks on the load/store unit
// Bound into every lsu instance
module lsuProps import lsuPkg::*; (
  input logic    clk,
  input logic    reset,
  input logic    StallW,
  input memReq_t reqM,                       // Request in M
  input word_t   ReadDataW,
  input logic    SquashSCW,
  input logic    scFailM,                    // SC in M has no valid reservation
  input logic    dtimWrEn                    // Qualified DTIM write
);

  int         failCount = 0;   // Assertion failures so far
  logic [2:0] alignMaskM;      // Low address bits that must be zero
  logic       misalignedM;     // M request off its size boundary

  assign alignMaskM  = (3'b001 << reqM.size[1:0]) - 3'b001;
  assign misalignedM = |(reqM.adr[2:0] & alignMaskM);

  ////////////////////
  // Reset
  ////////////////////

  squashClearedByReset: assert property (@(posedge clk) $past(reset) |-> !SquashSCW)
    else begin
      $error("SquashSCW is high after a reset cycle");
      failCount++;
    end

  ////////////////////
  // Write gating
  ////////////////////

  // A misaligned store never reaches memory
  noWriteOnFault: assert property (@(posedge clk) disable iff (reset)
    ((reqM.rw == RW_WRITE) & misalignedM) |-> !dtimWrEn)
    else begin
      $error("DTIM write enabled during a misaligned access");
      failCount++;
    end

  ////////////////////
  // W stage
  ////////////////////

  readDataHeld: assert property (@(posedge clk) disable iff (reset)
    $past(StallW) |-> $stable(ReadDataW))
    else begin
      $error("ReadDataW changed while StallW was high");
      failCount++;
    end

  squashAfterFail: assert property (@(posedge clk) disable iff (reset)
    $past(scFailM & ~StallW) |-> SquashSCW)
    else begin
      $error("Failed SC did not raise SquashSCW");
      failCount++;
    end

  noSquashAfterPass: assert property (@(posedge clk) disable iff (reset)
    $past(~scFailM & ~StallW) |-> !SquashSCW)   // Flag lasts one cycle
    else begin
      $error("SquashSCW high without a failed SC");
      failCount++;
    end

endmodule

bind lsu lsuProps lsuProps_i (.*);

/* hdl/lsu.sv */
`timescale 1ns/10ps

// Reduced load/store unit with a DTIM as the only memory
module lsu import lsuPkg::*; #(
  parameter int DTIM_ADR_BITS        = 6,   // log2 of the DTIM depth in words
  parameter bit BIG_ENDIAN_SUPPORTED = 1    // Build the byte swappers
) (
  input  logic    clk,
  input  logic    reset,
  input  logic    StallM,
  input  logic    FlushM,
  input  logic    StallW,
  input  memReq_t memReqE,                    // Request from the E stage
  input  word_t   WriteDataM,                 // Store data from the IEU
  input  logic    BigEndianM,                 // Swap byte order for this access
  output word_t   ReadDataW,                  // Load result to the register file
  output logic    SquashSCW,                  // Failed SC so write 1 to rd
  output logic    LoadMisalignedFaultM,
  output logic    StoreAmoMisalignedFaultM
);

  memReq_t   reqM;        // Request in the M stage
  word_t     storeDataM;  // Write data placed on its byte lanes
  byteMask_t byteMaskM;   // Byte enables for the write
  logic      scFailM;     // SC in M has lost its reservation
  logic      dtimWrEn;    // Write that actually reaches the DTIM
  word_t     readWordM;   // Raw DTIM word for the M-stage load
  word_t     ReadDataM;   // Extended load result

  ////////////////////
  // E to M request register
  ////////////////////

  // Payload follows the E stage unless M is stalled
  // A flush or reset turns the request into a bubble
  always_ff @(posedge clk) begin
    if (~StallM) reqM <= memReqE;
    if (reset | FlushM) reqM.rw <= RW_IDLE;   // Control field only
  end

  ////////////////////
  // Store side
  ////////////////////

  storePath #(
    .BIG_ENDIAN_SUPPORTED(BIG_ENDIAN_SUPPORTED)
  ) storePath_i (
    .reqM,
    .WriteDataM,
    .BigEndianM,
    .storeDataM,
    .byteMaskM,
    .LoadMisalignedFaultM,
    .StoreAmoMisalignedFaultM
  );

  // SC outcome and the squash flag for the W stage
  lrscReservation lrscReservation_i (
    .clk,
    .reset,
    .StallW,
    .reqM,
    .scFailM,
    .SquashSCW
  );

  // Commit only a clean aligned write that is not held in W
  assign dtimWrEn = (reqM.rw == RW_WRITE) & ~StoreAmoMisalignedFaultM
                  & ~StallW & ~scFailM;

  ////////////////////
  // Data memory
  ////////////////////

  // Read uses the E address so data is ready in M
  dtim #(
    .DTIM_ADR_BITS(DTIM_ADR_BITS)
  ) dtim_i (
    .clk,
    .rdEn     (~StallM),         // Hold the read word with the M stage
    .rdAdr    (memReqE.adr),
    .wrEn     (dtimWrEn),
    .wrAdr    (reqM.adr),
    .byteMask (byteMaskM),
    .wrData   (storeDataM),
    .readWordM
  );

  ////////////////////
  // Load side
  ////////////////////

  loadPath #(
    .BIG_ENDIAN_SUPPORTED(BIG_ENDIAN_SUPPORTED)
  ) loadPath_i (
    .readWordM,
    .size      (reqM.size),
    .offset    (byteOffset_t'(reqM.adr)),   // Low address bits
    .BigEndianM,
    .ReadDataM
  );

  // M to W read data register
  always_ff @(posedge clk) begin
    if (reset) ReadDataW <= '0;
    else if (~StallW) ReadDataW <= ReadDataM;
  end

endmodule

/* hdl/lrscReservation.sv */
`timescale 1ns/10ps

// Load-reserved / store-conditional tracking
module lrscReservation import lsuPkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    StallW,                    // Holds every update
  input  memReq_t reqM,                      // Request in M
  output logic    scFailM,                   // SC in M must not write
  output logic    SquashSCW                  // SC failed so rd gets 1
);

  localparam int OFF_BITS = $bits(byteOffset_t);

  typedef logic [XLEN-OFF_BITS-1:0] dwAdr_t;  // Doubleword address

  logic   isLrM;       // LR in M
  logic   isScM;       // SC in M
  dwAdr_t adrDwM;      // Doubleword of the M request
  logic   resValid;    // Reservation held
  dwAdr_t resAdr;      // Reserved doubleword

  assign isLrM  = reqM.lrsc & (reqM.rw == RW_READ);
  assign isScM  = reqM.lrsc & (reqM.rw == RW_WRITE);
  assign adrDwM = reqM.adr[XLEN-1:OFF_BITS];

  // SC needs a live reservation on the same doubleword
  assign scFailM = isScM & (~resValid | (resAdr != adrDwM));

  ////////////////////
  // Reservation
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      resValid <= 1'b0;
    end else if (~StallW) begin
      if (isLrM)      resValid <= 1'b1;      // New reservation
      else if (isScM) resValid <= 1'b0;      // Any SC consumes it
    end
  end

  // Doubleword captured by each LR that leaves M
  always_ff @(posedge clk) begin
    if (~StallW & isLrM) resAdr <= adrDwM;
  end

  ////////////////////
  // W-stage flag
  ////////////////////

  // One cycle after the SC leaves M
  always_ff @(posedge clk) begin
    if (reset) SquashSCW <= 1'b0;
    else if (~StallW) SquashSCW <= scFailM;
  end

endmodule

/* hdl/loadPath.sv */
`timescale 1ns/10ps

// Load data alignment and extension
module loadPath import lsuPkg::*; #(
  parameter bit BIG_ENDIAN_SUPPORTED = 1
) (
  input  word_t       readWordM,             // Word from the DTIM
  input  memSize_e    size,                  // funct3 of the load
  input  byteOffset_t offset,                // Byte position of the load
  input  logic        BigEndianM,
  output word_t       ReadDataM              // Result for the register file
);

  word_t leWordM;     // Word in little-endian order
  word_t shiftedM;    // Addressed byte moved to lane zero

  ////////////////////
  // Endian swap
  ////////////////////

  if (BIG_ENDIAN_SUPPORTED) begin : genSwap
    // Mirrors the swap on the store side
    always_comb begin
      if (BigEndianM) leWordM = {<<8{readWordM}};
      else            leWordM = readWordM;
    end
  end else begin : genNoSwap
    assign leWordM = readWordM;
  end

  ////////////////////
  // Subword select
  ////////////////////

  // Offset in bytes becomes a bit shift
  assign shiftedM = leWordM >> {offset, 3'b000};

  // Sign or zero fill above the subword
  always_comb begin
    case (size)
      SIZE_B:  ReadDataM = {{56{shiftedM[7]}}, shiftedM[7:0]};
      SIZE_H:  ReadDataM = {{48{shiftedM[15]}}, shiftedM[15:0]};
      SIZE_W:  ReadDataM = {{32{shiftedM[31]}}, shiftedM[31:0]};
      SIZE_D:  ReadDataM = shiftedM;
      SIZE_BU: ReadDataM = {56'b0, shiftedM[7:0]};
      SIZE_HU: ReadDataM = {48'b0, shiftedM[15:0]};
      SIZE_WU: ReadDataM = {32'b0, shiftedM[31:0]};
      default: ReadDataM = shiftedM;         // Unused code 111
    endcase
  end

endmodule

/* hdl/dtim.sv */
`timescale 1ns/10ps

// Data tightly-integrated memory
// One word wide with per-byte write enables
module dtim import lsuPkg::*; #(
  parameter int DTIM_ADR_BITS = 6            // log2 of depth in words
) (
  input  logic      clk,
  input  logic      rdEn,                    // Capture a new read word
  input  word_t     rdAdr,                   // E-stage address
  input  logic      wrEn,                    // Qualified M-stage write
  input  word_t     wrAdr,                   // M-stage address
  input  byteMask_t byteMask,
  input  word_t     wrData,
  output word_t     readWordM                // Word for the load now in M
);

  localparam int DEPTH    = 2 ** DTIM_ADR_BITS;
  localparam int OFF_BITS = $bits(byteOffset_t);      // Byte offset below the index
  localparam int IDX_HI   = DTIM_ADR_BITS + OFF_BITS - 1;

  typedef logic [DTIM_ADR_BITS-1:0] dtimIdx_t;

  word_t    mem [DEPTH];   // Storage array
  dtimIdx_t rdIdx;         // Word index of the read
  dtimIdx_t wrIdx;         // Word index of the write

  // Word index from the bits above the byte offset
  // Upper address bits alias onto the same words
  assign rdIdx = rdAdr[IDX_HI:OFF_BITS];
  assign wrIdx = wrAdr[IDX_HI:OFF_BITS];

  ////////////////////
  // Read port
  ////////////////////

  // Registered read so the word lines up with the M stage
  // A write in the same cycle is not forwarded
  always_ff @(posedge clk) begin
    if (rdEn) begin
      readWordM <= mem[rdIdx];
    end
  end

  ////////////////////
  // Write port
  ////////////////////

  // Only enabled lanes change
  always_ff @(posedge clk) begin
    if (wrEn) begin
      for (int b = 0; b < XBYTES; b++) begin
        if (byteMask[b]) begin
          mem[wrIdx][b*8 +: 8] <= wrData[b*8 +: 8];   // One byte lane
        end
      end
    end
  end

endmodule

/* hdl/storePath.sv */
`timescale 1ns/10ps

// Store data placement, byte mask and alignment check
module storePath import lsuPkg::*; #(
  parameter bit BIG_ENDIAN_SUPPORTED = 1
) (
  input  memReq_t   reqM,
  input  word_t     WriteDataM,
  input  logic      BigEndianM,
  output word_t     storeDataM,               // Data in memory byte order
  output byteMask_t byteMaskM,                // Lanes to write
  output logic      LoadMisalignedFaultM,
  output logic      StoreAmoMisalignedFaultM
);

  byteOffset_t offset;       // Byte position of the access
  word_t       leDataM;      // Replicated data in little-endian order
  byteMask_t   baseMask;     // Mask for offset zero
  byteMask_t   leMaskM;      // Mask shifted to the offset
  logic        misaligned;   // Address not a multiple of the size

  assign offset = byteOffset_t'(reqM.adr);

  ////////////////////
  // Subword replication
  ////////////////////

  // Copy the subword into every lane so any aligned offset finds it
  always_comb begin
    case (reqM.size[1:0])
      2'b00:   leDataM = {8{WriteDataM[7:0]}};
      2'b01:   leDataM = {4{WriteDataM[15:0]}};
      2'b10:   leDataM = {2{WriteDataM[31:0]}};
      default: leDataM = WriteDataM;             // Doubleword
    endcase
  end

  // Size decides the width of the mask and the alignment rule
  always_comb begin
    case (reqM.size[1:0])
      2'b00: begin
        baseMask   = 8'h01;
        misaligned = 1'b0;                       // Bytes are always aligned
      end
      2'b01: begin
        baseMask   = 8'h03;
        misaligned = offset[0];
      end
      2'b10: begin
        baseMask   = 8'h0f;
        misaligned = |offset[1:0];
      end
      default: begin
        baseMask   = 8'hff;
        misaligned = |offset;
      end
    endcase
  end

  assign leMaskM = baseMask << offset;

  // Fault type follows the direction of the access
  assign LoadMisalignedFaultM     = misaligned & (reqM.rw == RW_READ);
  assign StoreAmoMisalignedFaultM = misaligned & (reqM.rw == RW_WRITE);

  ////////////////////
  // Endian swap
  ////////////////////

  if (BIG_ENDIAN_SUPPORTED) begin : genSwap
    // Whole word reversed so data and lanes stay paired
    always_comb begin
      if (BigEndianM) begin
        storeDataM = {<<8{leDataM}};             // Byte reverse
        byteMaskM  = {<<{leMaskM}};              // Lane reverse
      end else begin
        storeDataM = leDataM;
        byteMaskM  = leMaskM;
      end
    end
  end else begin : genNoSwap
    assign storeDataM = leDataM;                 // Little-endian only
    assign byteMaskM  = leMaskM;
  end

endmodule

/* hdl/lsuPkg.sv */
// Shared widths and types for the load/store unit
package lsuPkg;

  ////////////////////
  // Widths
  ////////////////////

  localparam int XLEN = 64;                // Data and address width
  localparam int XBYTES = XLEN / 8;        // Bytes per word

  typedef logic [XLEN-1:0]           word_t;        // Data word or address
  typedef logic [XBYTES-1:0]         byteMask_t;    // One write enable per byte lane
  typedef logic [$clog2(XBYTES)-1:0] byteOffset_t;  // Byte position inside a word

  ////////////////////
  // Read/write control
  ////////////////////

  typedef logic [1:0] memRw_t;

  localparam memRw_t RW_IDLE  = 2'b00;     // No access
  localparam memRw_t RW_READ  = 2'b10;     // Load or LR
  localparam memRw_t RW_WRITE = 2'b01;     // Store or SC

  // Access size and sign as coded in funct3
  // Low two bits give log2 of the size and bit 2 marks unsigned
  typedef enum logic [2:0] {
    SIZE_B  = 3'b000,
    SIZE_H  = 3'b001,
    SIZE_W  = 3'b010,
    SIZE_D  = 3'b011,
    SIZE_BU = 3'b100,
    SIZE_HU = 3'b101,
    SIZE_WU = 3'b110
  } memSize_e;

  ////////////////////
  // Request bundle
  ////////////////////

  // Memory request as it travels from E to M
  typedef struct packed {
    memRw_t   rw;      // Read / write / idle
    memSize_e size;    // funct3 size code
    logic     lrsc;    // Set for LR and SC
    word_t    adr;     // Byte address
  } memReq_t;

endpackage
